//--- verilog/tenyr_pkg.sv
package tenyr_pkg;

    // ==================================================
    // Basic types
    // ==================================================

    typedef logic [31:0] word_t;

    // Data-bus request driven by the core.
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  rw;     // 1 means write.
        logic  valid;
    } bus_req_t;

    // ==================================================
    // Instruction word
    // ==================================================

    typedef struct packed {
        logic [1:0]        fmt;
        logic [1:0]        dd;    // Destination kind.
        logic [3:0]        z;
        logic [3:0]        x;
        logic [3:0]        y;
        logic [3:0]        op;
        logic signed [11:0] imm12;
    } reg_form_t;

    typedef struct packed {
        logic [1:0]         fmt;
        logic [1:0]         dd;
        logic [3:0]         z;
        logic signed [23:0] imm24;
    } imm_form_t;

    // Both views share fmt, dd and z at the same bit positions.
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } insn_t;

    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_and    = 4'd2,
        op_or     = 4'd3,
        op_xor    = 4'd4,
        op_shl    = 4'd5,  // Shift by low 5 bits of y.
        op_cmp_eq = 4'd6   // All ones when equal.
    } op_e;

    localparam logic [1:0] fmt_reg = 2'd0;
    localparam logic [1:0] fmt_imm = 2'd1;  // Formats 2 and 3 are illegal.

    localparam logic [1:0] dd_reg   = 2'd0;
    localparam logic [1:0] dd_load  = 2'd1;
    localparam logic [1:0] dd_store = 2'd2;

    // ==================================================
    // Address map and halt bits
    // ==================================================

    localparam int          ram_words = 1024;
    localparam int          ram_aw    = $clog2(ram_words);
    localparam logic [11:0] seg7_base = 12'h100;

    localparam int halt_tenyr    = 0;
    localparam int halt_external = 1;

    localparam logic [3:0] reg_p = 4'd15;  // Program counter.

endpackage

//--- verilog/tenyr_core.sv
module tenyr_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                halt_in,
    output tenyr_pkg::word_t    insn_addr,
    input  tenyr_pkg::insn_t    insn,
    output tenyr_pkg::bus_req_t req,
    input  tenyr_pkg::word_t    rdata,
    output logic [1:0]          halted
);
    import tenyr_pkg::*;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_wb
    } state_e;

    state_e     state;
    word_t      pc;
    word_t      regs [16];
    logic [3:0] wb_z;       // Load target held for writeback.
    logic       halt_tenyr_q;
    logic       halt_ext_q;

    logic [1:0] fmt;
    logic [1:0] dd;
    logic [3:0] dst;
    logic       legal;
    logic       is_load;
    logic       is_store;
    word_t      op_a;
    word_t      op_b;
    word_t      alu_out;
    word_t      result;
    word_t      store_val;

    // Register 0 reads zero, P reads as the next address.
    function automatic word_t read_reg(input logic [3:0] idx);
        word_t val;
        if (idx == 4'd0)
            val = '0;
        else if (idx == reg_p)
            val = pc + 32'd1;
        else
            val = regs[idx];
        return val;
    endfunction

    // ==================================================
    // Decode and execute
    // ==================================================

    always_comb begin
        fmt      = insn.reg_form.fmt;
        dd       = insn.reg_form.dd;
        dst      = insn.reg_form.z;
        legal    = (fmt == fmt_reg) || (fmt == fmt_imm);
        is_load  = (dd == dd_load);
        is_store = (dd == dd_store);
        op_a     = read_reg(insn.reg_form.x);
        op_b     = read_reg(insn.reg_form.y);
        store_val = read_reg(dst);

        case (op_e'(insn.reg_form.op))
            op_add:    alu_out = op_a + op_b;
            op_sub:    alu_out = op_a - op_b;
            op_and:    alu_out = op_a & op_b;
            op_or:     alu_out = op_a | op_b;
            op_xor:    alu_out = op_a ^ op_b;
            op_shl:    alu_out = op_a << op_b[4:0];
            op_cmp_eq: alu_out = (op_a == op_b) ? '1 : '0;
            default:   alu_out = '0;  // Unused op codes.
        endcase

        if (fmt == fmt_imm)
            result = {{8{insn.imm_form.imm24[23]}}, insn.imm_form.imm24};
        else
            result = alu_out + {{20{insn.reg_form.imm12[11]}}, insn.reg_form.imm12};
    end

    // Bus request only in execute, and only for memory kinds.
    always_comb begin
        req.addr  = result;
        req.wdata = store_val;
        req.rw    = is_store;
        req.valid = (state == st_exec) && legal && (is_load || is_store);
    end

    assign insn_addr             = pc;
    assign halted[halt_tenyr]    = halt_tenyr_q;
    assign halted[halt_external] = halt_ext_q;

    // ==================================================
    // Control FSM
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_fetch;
            pc           <= '0;
            halt_tenyr_q <= 1'b0;
            halt_ext_q   <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    halt_ext_q <= halt_in;  // Sampled only between instructions.
                    if (!halt_in && !halt_tenyr_q)
                        state <= st_exec;
                end
                st_exec: begin
                    state <= st_fetch;
                    if (!legal)
                        halt_tenyr_q <= 1'b1;  // Sticky until reset.
                    else if (is_load)
                        state <= st_wb;
                    else if (!is_store && dst == reg_p)
                        pc <= result;  // Jump.
                    else
                        pc <= pc + 32'd1;
                end
                st_wb: begin
                    state <= st_fetch;
                    pc    <= (wb_z == reg_p) ? rdata : pc + 32'd1;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // Register file and load target.
    always_ff @(posedge clk) begin
        if (!reset && state == st_exec && legal) begin
            if (is_load)
                wb_z <= dst;
            else if (!is_store)
                regs[dst] <= result;
        end
        if (!reset && state == st_wb)
            regs[wb_z] <= rdata;
    end

endmodule

//--- verilog/block_ram.sv
module block_ram (
    input  logic                            clk,
    input  tenyr_pkg::bus_req_t             req,
    input  logic                            ram_sel,
    output tenyr_pkg::word_t                rdata,
    input  tenyr_pkg::word_t                insn_addr,
    output tenyr_pkg::word_t                insn,
    input  logic                            load_en,
    input  logic [tenyr_pkg::ram_aw-1:0]    load_addr,
    input  tenyr_pkg::word_t                load_data
);
    import tenyr_pkg::*;

    word_t mem [ram_words];

    logic [ram_aw-1:0] addr_a;
    logic [ram_aw-1:0] addr_b;

    assign addr_a = req.addr[ram_aw-1:0];
    assign addr_b = insn_addr[ram_aw-1:0];

    // ==================================================
    // Both ports in one process
    // ==================================================

    always_ff @(posedge clk) begin
        // Port A serves the data bus.
        if (ram_sel && req.valid) begin
            if (req.rw)
                mem[addr_a] <= req.wdata;
            else
                rdata <= mem[addr_a];
        end

        // Port B fetches, or takes boot-load words.
        if (load_en)
            mem[load_addr] <= load_data;
        insn <= mem[addr_b];
    end

endmodule

//--- verilog/seg7_display.sv
module seg7_display #(
    parameter int scan_bits = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  tenyr_pkg::bus_req_t req,
    input  logic                dev_sel,
    output tenyr_pkg::word_t    rdata,
    output logic [7:0]          seg,
    output logic [3:0]          an
);
    import tenyr_pkg::*;

    logic [15:0]          value;
    logic [scan_bits+1:0] scan_cnt;
    logic [1:0]           digit;
    logic [3:0]           nibble;

    // Active-high segments, gfedcba.
    function automatic logic [6:0] hex_segs(input logic [3:0] hex);
        logic [6:0] s;
        case (hex)
            4'h0: s = 7'h3f;
            4'h1: s = 7'h06;
            4'h2: s = 7'h5b;
            4'h3: s = 7'h4f;
            4'h4: s = 7'h66;
            4'h5: s = 7'h6d;
            4'h6: s = 7'h7d;
            4'h7: s = 7'h07;
            4'h8: s = 7'h7f;
            4'h9: s = 7'h6f;
            4'ha: s = 7'h77;
            4'hb: s = 7'h7c;
            4'hc: s = 7'h39;
            4'hd: s = 7'h5e;
            4'he: s = 7'h79;
            default: s = 7'h71;
        endcase
        return s;
    endfunction

    // ==================================================
    // Bus side
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset)
            value <= '0;
        else if (dev_sel && req.valid && req.rw)
            value <= req.wdata[15:0];  // Low half only.
    end

    always_ff @(posedge clk) begin
        rdata <= {16'h0000, value};
    end

    // Scan one digit per 2^scan_bits cycles.
    always_ff @(posedge clk) begin
        if (reset)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    assign digit  = scan_cnt[scan_bits+1:scan_bits];
    assign nibble = value[digit*4 +: 4];
    assign an     = ~(4'b0001 << digit);      // One-cold.
    assign seg    = {1'b1, ~hex_segs(nibble)};  // Point stays off.

endmodule

//--- verilog/tenyr_soc.sv
module tenyr_soc #(
    parameter int scan_bits = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         halt,
    input  logic                         load_en,
    input  logic [tenyr_pkg::ram_aw-1:0] load_addr,
    input  tenyr_pkg::word_t             load_data,
    output logic [7:0]                   led,
    output logic [7:0]                   seg,
    output logic [3:0]                   an
);
    import tenyr_pkg::*;

    bus_req_t   req;
    word_t      insn_addr;
    word_t      insn_word;
    word_t      core_rdata;
    word_t      ram_rdata;
    word_t      dev_rdata;
    logic [1:0] halted;
    logic       ram_sel;
    logic       dev_sel;
    logic       ram_sel_q;
    logic       dev_sel_q;

    // ==================================================
    // Address decode and read mux
    // ==================================================

    assign ram_sel = req.addr < ram_words;
    assign dev_sel = req.addr == {20'h00000, seg7_base};

    always_ff @(posedge clk) begin
        if (reset) begin
            ram_sel_q <= 1'b0;
            dev_sel_q <= 1'b0;
        end else begin
            ram_sel_q <= ram_sel;  // Read data lags the request by one cycle.
            dev_sel_q <= dev_sel;
        end
    end

    assign core_rdata = ram_sel_q ? ram_rdata : (dev_sel_q ? dev_rdata : '0);
    assign led        = {6'b000000, halted};

    tenyr_core core_i (
        .clk       ( clk        ), .insn_addr ( insn_addr  ), .req    ( req    ),
        .reset     ( reset      ), .insn      ( insn_word  ), .rdata  ( core_rdata ),
        .halt_in   ( halt       ), .halted    ( halted     )
    );

    // Boot load is only honoured while the core is held in reset.
    block_ram ram_i (
        .clk       ( clk             ), .insn_addr ( insn_addr ), .load_addr ( load_addr ),
        .req       ( req             ), .insn      ( insn_word ), .load_data ( load_data ),
        .ram_sel   ( ram_sel         ), .rdata     ( ram_rdata ),
        .load_en   ( load_en & reset )
    );

    seg7_display #(.scan_bits(scan_bits)) seg7_i (
        .clk     ( clk     ), .req     ( req       ), .seg ( seg ),
        .reset   ( reset   ), .dev_sel ( dev_sel   ), .an  ( an  ),
        .rdata   ( dev_rdata )
    );

endmodule

//--- testbench/soc_asserts.sv
module soc_asserts (
    input logic       clk,
    input logic       reset,
    input logic [3:0] an,
    input logic       req_valid,
    input logic [1:0] halted
);
    timeunit 1ns;
    timeprecision 100ps;

    // ==================================================
    // Scan and bus properties
    // ==================================================

    // Exactly one digit driven low.
    an_one_cold: assert property (@(posedge clk) disable iff (reset)
        $onehot(~an))
        else $error("Anode enables are not one-cold.");

    reset_no_valid: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !req_valid)
        else $error("Bus valid is high during reset.");

    halt_no_req: assert property (@(posedge clk) disable iff (reset)
        (halted != 2'b00) |-> !req_valid)
        else $error("Bus request issued while halted.");

endmodule

//--- testbench/soc_checker.sv
module soc_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  logic        check_en,
    input  logic [7:0]  seg,
    input  logic [3:0]  an,
    input  logic [7:0]  led,
    input  logic [15:0] exp_value,
    input  logic [7:0]  exp_led,
    input  int          row_id,
    output logic        stable,
    output int          errors,
    output int          checks
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0]  digits [4];
    logic [3:0]  seen;
    logic [15:0] shown;
    logic [15:0] last_full;
    logic        last_valid;
    logic [1:0]  idx;
    logic        idx_ok;
    logic [4:0]  dec;
    logic [15:0] full;
    int          err_cnt = 0;
    int          chk_cnt = 0;

    // Lit segments gfedcba back to a hex digit, bit 4 marks a known pattern.
    function automatic logic [4:0] seg_to_hex(input logic [6:0] lit);
        case (lit)
            7'h3f: return 5'h10;
            7'h06: return 5'h11;
            7'h5b: return 5'h12;
            7'h4f: return 5'h13;
            7'h66: return 5'h14;
            7'h6d: return 5'h15;
            7'h7d: return 5'h16;
            7'h07: return 5'h17;
            7'h7f: return 5'h18;
            7'h6f: return 5'h19;
            7'h77: return 5'h1a;
            7'h7c: return 5'h1b;
            7'h39: return 5'h1c;
            7'h5e: return 5'h1d;
            7'h79: return 5'h1e;
            7'h71: return 5'h1f;
            default: return 5'h00;
        endcase
    endfunction

    always_comb begin
        idx_ok = 1'b1;
        case (an)
            4'b1110: idx = 2'd0;
            4'b1101: idx = 2'd1;
            4'b1011: idx = 2'd2;
            4'b0111: idx = 2'd3;
            default: begin
                idx    = 2'd0;
                idx_ok = 1'b0;
            end
        endcase
        dec  = seg_to_hex(~seg[6:0]);
        full = {dec[3:0], digits[2], digits[1], digits[0]};
    end

    assign errors = err_cnt;
    assign checks = chk_cnt;

    // ==================================================
    // Scan capture and compare
    // ==================================================

    always @(posedge clk) begin
        if (reset || clear) begin
            seen       <= 4'b0000;
            stable     <= 1'b0;
            last_valid <= 1'b0;
        end else if (idx_ok) begin
            if (!dec[4] || !seg[7]) begin
                err_cnt = err_cnt + 1;
                $display("Error at %0t ns: segment pattern %h on digit %0d is not a hex digit.",
                         $time, seg, idx);
            end
            digits[idx] <= dec[3:0];
            seen[idx]   <= 1'b1;
            // Last digit closes a full scan, then a new scan starts.
            if (idx == 2'd3 && seen[2:0] == 3'b111) begin
                stable     <= last_valid && (full == last_full);
                last_full  <= full;
                last_valid <= 1'b1;
                shown      <= full;
                seen       <= 4'b0000;
            end
        end

        if (check_en) begin
            chk_cnt = chk_cnt + 1;
            if (shown !== exp_value || led !== exp_led) begin
                err_cnt = err_cnt + 1;
                $display("Error at %0t ns: row %0d shows %h led %h, expected %h led %h",
                         $time, row_id, shown, led, exp_value, exp_led);
            end
        end
    end

endmodule

//--- testbench/tb_tenyr_soc.sv
module tb_tenyr_soc;
    timeunit 1ns;
    timeprecision 100ps;
    import tenyr_pkg::*;

    localparam int n_rows      = 15;
    localparam int prog_len    = 16;
    localparam int scan_cycles = 64;   // Four digits of 2^4 cycles each.
    localparam int row_cycles  = 4 + prog_len + 10 * scan_cycles;
    localparam int clk_period  = 20;
    localparam longint watchdog_ns = longint'(n_rows * row_cycles + 4 * scan_cycles) * clk_period;

    logic                  clk;
    logic                  reset;
    logic                  halt;
    logic                  load_en;
    logic [ram_aw-1:0]     load_addr;
    word_t                 load_data;
    logic [7:0]            led;
    logic [7:0]            seg;
    logic [3:0]            an;

    logic                  clear;
    logic                  check_en;
    logic [15:0]           exp_now;
    logic [7:0]            exp_led_now;
    int                    row_id;
    logic                  stable;
    int                    errors;
    int                    checks;

    // Program table with hand-derived expected values.
    word_t                 prog [n_rows][prog_len];
    logic [15:0]           exp_value [n_rows];
    logic [7:0]            exp_led [n_rows];
    bit                    hold_halt [n_rows];
    integer                seed = 32'h45a61ce4;

    tenyr_soc dut_i (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .halt      ( halt      ),
        .load_en   ( load_en   ),
        .load_addr ( load_addr ),
        .load_data ( load_data ),
        .led       ( led       ),
        .seg       ( seg       ),
        .an        ( an        )
    );

    soc_checker checker_i (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .clear     ( clear       ),
        .check_en  ( check_en    ),
        .seg       ( seg         ),
        .an        ( an          ),
        .led       ( led         ),
        .exp_value ( exp_now     ),
        .exp_led   ( exp_led_now ),
        .row_id    ( row_id      ),
        .stable    ( stable      ),
        .errors    ( errors      ),
        .checks    ( checks      )
    );

    bind tenyr_soc soc_asserts asserts_i (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .an        ( an        ),
        .req_valid ( req.valid ),
        .halted    ( halted    )
    );

    // ==================================================
    // Instruction encoding
    // ==================================================

    function automatic word_t enc_imm(input logic [1:0] dd, input logic [3:0] z,
                                      input logic [23:0] imm);
        return {fmt_imm, dd, z, imm};
    endfunction

    function automatic word_t enc_reg(input logic [1:0] dd, input logic [3:0] z,
                                      input logic [3:0] x, input logic [3:0] y,
                                      input logic [3:0] op, input logic [11:0] imm);
        return {fmt_reg, dd, z, x, y, op, imm};
    endfunction

    function automatic word_t display_store(input logic [3:0] z);
        return enc_reg(dd_store, z, 4'd0, 4'd0, op_add, 12'h100);
    endfunction

    // P reads as pc + 1, so adding -1 loops in place.
    function automatic word_t self_jump();
        return enc_reg(dd_reg, reg_p, reg_p, 4'd0, op_add, 12'hfff);
    endfunction

    task automatic set_alu_row(input int r, input logic [3:0] op, input logic [23:0] a,
                               input logic [23:0] b, input logic [11:0] imm,
                               input logic [15:0] expv);
        prog[r][0]   = enc_imm(dd_reg, 4'd1, a);
        prog[r][1]   = enc_imm(dd_reg, 4'd2, b);
        prog[r][2]   = enc_reg(dd_reg, 4'd3, 4'd1, 4'd2, op, imm);
        prog[r][3]   = display_store(4'd3);
        prog[r][4]   = self_jump();
        exp_value[r] = expv;
    endtask

    task automatic build_table();
        logic [15:0] rnd;
        for (int r = 0; r < n_rows; r++) begin
            for (int i = 0; i < prog_len; i++)
                prog[r][i] = '0;
            exp_led[r]   = 8'h00;
            hold_halt[r] = 1'b0;
        end

        // Immediate write, low half of a negative value.
        prog[0][0] = enc_imm(dd_reg, 4'd1, 24'hffabcd);
        prog[0][1] = display_store(4'd1);
        prog[0][2] = self_jump();
        exp_value[0] = 16'habcd;

        set_alu_row(1, op_add, 24'h00f0f3, 24'h003c35, 12'h000, 16'h2d28);
        set_alu_row(2, op_sub, 24'h00f0f3, 24'h003c35, 12'h000, 16'hb4be);
        set_alu_row(3, op_and, 24'h00f0f3, 24'h003c35, 12'h000, 16'h3031);
        set_alu_row(4, op_or,  24'h00f0f3, 24'h003c35, 12'h000, 16'hfcf7);
        set_alu_row(5, op_xor, 24'h00f0f3, 24'h003c35, 12'h000, 16'hccc6);
        set_alu_row(6, op_shl, 24'h00f0f3, 24'h000000, 12'h000, 16'hf0f3);
        set_alu_row(7, op_shl, 24'h00f0f3, 24'h000024, 12'h000, 16'h0f30);  // Only 5 bits used.
        set_alu_row(8, op_cmp_eq, 24'h00f0f3, 24'h003c35, 12'h012, 16'h0012);
        set_alu_row(9, op_cmp_eq, 24'h00f0f3, 24'h00f0f3, 12'h012, 16'h0011);

        // Store to RAM, load back into another register.
        prog[10][0] = enc_imm(dd_reg, 4'd1, 24'h007e5d);
        prog[10][1] = enc_reg(dd_store, 4'd1, 4'd0, 4'd0, op_add, 12'h200);
        prog[10][2] = enc_reg(dd_load, 4'd4, 4'd0, 4'd0, op_add, 12'h200);
        prog[10][3] = display_store(4'd4);
        prog[10][4] = self_jump();
        exp_value[10] = 16'h7e5d;

        // Conditional skip over words 6 to 8, the skipped path parks on its own value.
        prog[11][0]  = enc_imm(dd_reg, 4'd1, 24'd5);
        prog[11][1]  = enc_imm(dd_reg, 4'd2, 24'd5);
        prog[11][2]  = enc_imm(dd_reg, 4'd5, 24'd3);
        prog[11][3]  = enc_reg(dd_reg, 4'd3, 4'd1, 4'd2, op_cmp_eq, 12'h000);
        prog[11][4]  = enc_reg(dd_reg, 4'd4, 4'd3, 4'd5, op_and, 12'h000);
        prog[11][5]  = enc_reg(dd_reg, reg_p, reg_p, 4'd4, op_add, 12'h000);
        prog[11][6]  = enc_imm(dd_reg, 4'd6, 24'h00dead);
        prog[11][7]  = display_store(4'd6);
        prog[11][8]  = self_jump();
        prog[11][9]  = enc_imm(dd_reg, 4'd6, 24'h00600d);
        prog[11][10] = display_store(4'd6);
        prog[11][11] = self_jump();
        exp_value[11] = 16'h600d;

        // Illegal format stops the core before the second store.
        prog[12][0] = enc_imm(dd_reg, 4'd1, 24'h001111);
        prog[12][1] = display_store(4'd1);
        prog[12][2] = 32'hc000_0000;
        prog[12][3] = enc_imm(dd_reg, 4'd2, 24'h002222);
        prog[12][4] = display_store(4'd2);
        prog[12][5] = self_jump();
        exp_value[12] = 16'h1111;
        exp_led[12]   = 8'h01;

        // External halt held from reset release.
        prog[13][0] = enc_imm(dd_reg, 4'd1, 24'h004a7f);
        prog[13][1] = display_store(4'd1);
        prog[13][2] = self_jump();
        exp_value[13] = 16'h4a7f;
        hold_halt[13] = 1'b1;

        rnd = 16'($random(seed));
        prog[14][0] = enc_imm(dd_reg, 4'd1, {8'h00, rnd});
        prog[14][1] = display_store(4'd1);
        prog[14][2] = self_jump();
        exp_value[14] = rnd;
    endtask

    // ==================================================
    // Clock, stimulus and watchdog
    // ==================================================

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic wait_stable();
        do begin
            @(posedge clk);
            #1;
        end while (!stable);
    endtask

    task automatic run_check(input int r, input logic [15:0] v, input logic [7:0] l);
        row_id      = r;
        exp_now     = v;
        exp_led_now = l;
        check_en    = 1'b1;
        @(posedge clk);
        #1;
        check_en    = 1'b0;
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired: the display never settled within the time limit.");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        halt        = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        clear       = 1'b0;
        check_en    = 1'b0;
        exp_now     = '0;
        exp_led_now = '0;
        row_id      = 0;
        build_table();

        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            #1;
            reset = 1'b1;
            halt  = 1'b0;
            repeat (4) begin
                @(posedge clk);
                #1;
            end
            for (int i = 0; i < prog_len; i++) begin
                load_en   = 1'b1;
                load_addr = ram_aw'(i);
                load_data = prog[r][i];
                @(posedge clk);
                #1;
            end
            load_en = 1'b0;
            reset   = 1'b0;
            halt    = hold_halt[r];

            if (hold_halt[r]) begin
                wait_stable();
                run_check(r, 16'h0000, 8'h02);   // Frozen at the reset value.
                halt  = 1'b0;
                clear = 1'b1;
                @(posedge clk);
                #1;
                clear = 1'b0;
            end
            wait_stable();
            run_check(r, exp_value[r], exp_led[r]);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks == n_rows + 1)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- verilog.f
verilog/tenyr_pkg.sv
verilog/tenyr_core.sv
verilog/block_ram.sv
verilog/seg7_display.sv
verilog/tenyr_soc.sv
testbench/soc_asserts.sv
testbench/soc_checker.sv
testbench/tb_tenyr_soc.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_tenyr_soc
FILELIST   := verilog.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
